// File: cache_macros.svh
// Cache geometry and derived field widths.
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Byte address width of the CPU and external buses.
`define CACHE_ALEN 24

// Words in one cache line.
`define CACHE_LINE_WORDS 16

// Lines held by each way.
`define CACHE_SETS 32

// Number of ways.
`define CACHE_WAYS 2

// Word offset within a line.
`define CACHE_OFS_W 4

// Set index.
`define CACHE_IDX_W 5

// Tag, the word address bits above index and offset.
`define CACHE_TAG_W 13

// Way number.
`define CACHE_WAY_W 1

`endif

// File: cache_pkg.sv
// Cache package with the address union, bus structs, tag structs and lookup result.
`include "cache_macros.svh"

package cache_pkg;

    // Word address, seen flat on the external bus or split inside the cache.
    typedef union packed {
        logic [`CACHE_ALEN-3:0] flat;
        struct packed {
            logic [`CACHE_TAG_W-1:0] tag;
            logic [`CACHE_IDX_W-1:0] index;
            logic [`CACHE_OFS_W-1:0] offset;
        } f;
    } word_addr_u;

    typedef struct packed {
        logic       re;
        logic       we;
        word_addr_u addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic       re;
        logic       we;
        word_addr_u addr;
        logic [31:0] wdata;
    } xm_req_t;

    typedef struct packed {
        logic                    valid;
        logic                    dirty;
        logic [`CACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    // One tag RAM word: every way of a set plus the round-robin pointer.
    typedef struct packed {
        tag_entry_t [`CACHE_WAYS-1:0] way;
        logic [`CACHE_WAY_W-1:0]      next;
    } tag_set_t;

    typedef struct packed {
        cpu_req_t                req;
        logic                    hit;
        logic [`CACHE_WAY_W-1:0] hit_way;
        logic [`CACHE_WAY_W-1:0] victim_way;
        logic                    victim_dirty;
        logic [`CACHE_TAG_W-1:0] victim_tag;
    } lookup_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } cpu_resp_t;

endpackage

// File: tag_lookup.sv
// Request capture, tag RAM, hit decode and tag update merge.
`timescale 1ns/10ps
`include "cache_macros.svh"

module tag_lookup (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::cpu_req_t cpu_req,
    input  logic                busy,
    input  logic                tag_upd_we,
    input  cache_pkg::tag_set_t tag_upd,
    output cache_pkg::lookup_t  lookup
);
    import cache_pkg::*;

    tag_set_t                tag_ram [`CACHE_SETS];
    cpu_req_t                req_q;
    tag_set_t                tag_q;
    logic [`CACHE_IDX_W-1:0] rd_idx;
    logic [`CACHE_IDX_W-1:0] wr_idx;
    logic [`CACHE_WAYS-1:0]  match;
    logic                    hit;
    logic [`CACHE_WAY_W-1:0] hit_way;
    logic                    wr_en;
    tag_set_t                wr_set;

    // While a miss is serviced the held request keeps its set on the read port.
    assign rd_idx = busy ? req_q.addr.f.index : cpu_req.addr.f.index;
    assign wr_idx = req_q.addr.f.index;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= '0;
        end else if (!busy) begin
            req_q <= cpu_req;
        end
    end

    // Tag RAM; a write to the set being read is forwarded.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                tag_ram[i] <= '0;
            end
            tag_q <= '0;
        end else begin
            if (wr_en) begin
                tag_ram[wr_idx] <= wr_set;
            end
            if (wr_en && wr_idx == rd_idx) begin
                tag_q <= wr_set;
            end else begin
                tag_q <= tag_ram[rd_idx];
            end
        end
    end

    // Hit decode.
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            match[w] = tag_q.way[w].valid && tag_q.way[w].tag == req_q.addr.f.tag;
            if (match[w]) begin
                hit_way = `CACHE_WAY_W'(w);
            end
        end
        hit = |match;
    end

    // Refill updates replace the victim entry; write hits only set dirty.
    always_comb begin
        wr_set = tag_q;
        wr_en  = 1'b0;
        if (tag_upd_we) begin
            wr_en                  = 1'b1;
            wr_set.way[tag_q.next] = tag_upd.way[tag_q.next];
            wr_set.next            = tag_upd.next;
        end else if (req_q.we && hit && !busy) begin
            wr_en                    = 1'b1;
            wr_set.way[hit_way].dirty = 1'b1;
        end
    end

    always_comb begin
        lookup              = '0;
        lookup.req          = req_q;
        lookup.hit          = hit;
        lookup.hit_way      = hit_way;
        lookup.victim_way   = tag_q.next;
        lookup.victim_dirty = tag_q.way[tag_q.next].valid && tag_q.way[tag_q.next].dirty;
        lookup.victim_tag   = tag_q.way[tag_q.next].tag;
    end

endmodule

// File: data_store.sv
// Data RAM for all ways, with per-way write enables and read words.
`timescale 1ns/10ps
`include "cache_macros.svh"

module data_store (
    input  logic                                     clk,
    input  logic [`CACHE_IDX_W+`CACHE_OFS_W-1:0]     rd_index,
    input  logic                                     wr_en,
    input  logic [`CACHE_WAY_W-1:0]                  wr_way,
    input  logic [`CACHE_IDX_W+`CACHE_OFS_W-1:0]     wr_addr,
    input  logic [31:0]                              wr_data,
    output logic [`CACHE_WAYS-1:0][31:0]             rd_words
);

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        logic [31:0] mem [`CACHE_SETS*`CACHE_LINE_WORDS];
        logic [31:0] rd_q;
        logic        way_we;

        // Way decode.
        assign way_we = wr_en && (wr_way == `CACHE_WAY_W'(w));

        always_ff @(posedge clk) begin
            if (way_we) begin
                mem[wr_addr] <= wr_data;
            end
            // Same-address write is returned directly.
            if (way_we && wr_addr == rd_index) begin
                rd_q <= wr_data;
            end else begin
                rd_q <= mem[rd_index];
            end
        end

        assign rd_words[w] = rd_q;
    end

endmodule

// File: line_transfer.sv
// Miss FSM with dirty write-back, line fill, hit data return and external bus control.
`timescale 1ns/10ps
`include "cache_macros.svh"

module line_transfer (
    input  logic                                 clk,
    input  logic                                 rst,
    input  cache_pkg::lookup_t                   lookup,
    input  cache_pkg::word_addr_u                cpu_addr,
    input  logic [`CACHE_WAYS-1:0][31:0]         rd_words,
    input  logic                                 xm_ready,
    input  logic [31:0]                          xm_rdata,
    output cache_pkg::xm_req_t                   xm_req,
    output logic                                 busy,
    output logic                                 tag_upd_we,
    output cache_pkg::tag_set_t                  tag_upd,
    output logic                                 wr_en,
    output logic [`CACHE_WAY_W-1:0]              wr_way,
    output logic [`CACHE_IDX_W+`CACHE_OFS_W-1:0] wr_addr,
    output logic [31:0]                          wr_data,
    output logic [`CACHE_IDX_W+`CACHE_OFS_W-1:0] rd_index,
    output cache_pkg::cpu_resp_t                 cpu_resp
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WB,
        S_FILL,
        S_DONE
    } state_t;

    state_t                  state;
    logic [`CACHE_OFS_W-1:0] cnt;
    logic [`CACHE_WAY_W-1:0] vway;
    logic [`CACHE_TAG_W-1:0] vtag;
    logic [`CACHE_IDX_W-1:0] idx;
    logic [`CACHE_WAY_W-1:0] way_sel;
    logic                    req_valid;
    logic                    miss;
    logic                    wr_hit;
    logic                    last;

    assign idx       = lookup.req.addr.f.index;
    assign req_valid = lookup.req.re || lookup.req.we;
    assign miss      = state == S_IDLE && req_valid && !lookup.hit;
    assign wr_hit    = state == S_IDLE && lookup.req.we && lookup.hit;
    assign last      = cnt == `CACHE_OFS_W'(`CACHE_LINE_WORDS - 1);
    assign busy      = state != S_IDLE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (miss) begin
                        state <= lookup.victim_dirty ? S_WB : S_FILL;
                        cnt   <= '0;
                    end
                end
                S_WB: begin
                    if (xm_ready) begin
                        cnt <= cnt + 1'b1;
                        if (last) begin
                            state <= S_FILL;
                        end
                    end
                end
                S_FILL: begin
                    if (xm_ready) begin
                        cnt <= cnt + 1'b1;
                        if (last) begin
                            state <= S_DONE;
                        end
                    end
                end
                default: begin
                    // Gives the replay read one cycle after the last fill word.
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Victim captured when the miss is seen.
    always_ff @(posedge clk) begin
        if (miss) begin
            vway <= lookup.victim_way;
            vtag <= lookup.victim_tag;
        end
    end

    // External bus.
    always_comb begin
        xm_req = '0;
        if (state == S_WB) begin
            xm_req.we             = 1'b1;
            xm_req.addr.f.tag    = vtag;
            xm_req.addr.f.index  = idx;
            xm_req.addr.f.offset = cnt;
            xm_req.wdata          = rd_words[vway];
        end else if (state == S_FILL) begin
            xm_req.re             = 1'b1;
            xm_req.addr.f.tag    = lookup.req.addr.f.tag;
            xm_req.addr.f.index  = idx;
            xm_req.addr.f.offset = cnt;
        end
    end

    // Write-back reads the data one word ahead unless stalled.
    always_comb begin
        if (miss) begin
            rd_index = {idx, `CACHE_OFS_W'(0)};
        end else if (state == S_WB) begin
            rd_index = {idx, xm_ready ? cnt + 1'b1 : cnt};
        end else if (state == S_IDLE) begin
            rd_index = {cpu_addr.f.index, cpu_addr.f.offset};
        end else begin
            rd_index = {idx, lookup.req.addr.f.offset};
        end
    end

    // The victim way gets the new clean tag and the pointer moves past it.
    assign way_sel    = state == S_IDLE ? lookup.victim_way : vway;
    assign tag_upd_we = (miss && !lookup.victim_dirty) || (state == S_WB && xm_ready && last);

    always_comb begin
        tag_upd                    = '0;
        tag_upd.way[way_sel].valid = 1'b1;
        tag_upd.way[way_sel].tag   = lookup.req.addr.f.tag;
        tag_upd.next               = way_sel + 1'b1;
    end

    // CPU write hits and fill words share the data write port.
    always_comb begin
        wr_en   = 1'b0;
        wr_way  = vway;
        wr_addr = {idx, cnt};
        wr_data = xm_rdata;
        if (wr_hit) begin
            wr_en   = 1'b1;
            wr_way  = lookup.hit_way;
            wr_addr = {idx, lookup.req.addr.f.offset};
            wr_data = lookup.req.wdata;
        end else if (state == S_FILL) begin
            wr_en = xm_ready;
        end
    end

    assign cpu_resp.ready = state == S_IDLE && (!req_valid || lookup.hit);
    assign cpu_resp.rdata = rd_words[lookup.hit_way];

endmodule

// File: cache_top.sv
// Cache top level wiring the tag lookup, data store and line transfer stages.
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  cache_pkg::cpu_req_t  cpu_req,
    output cache_pkg::cpu_resp_t cpu_resp,
    output cache_pkg::xm_req_t   xm_req,
    input  logic                 xm_ready,
    input  logic [31:0]          xm_rdata
);
    import cache_pkg::*;

    lookup_t                              lookup;
    tag_set_t                             tag_upd;
    logic                                 tag_upd_we;
    logic                                 busy;
    logic                                 wr_en;
    logic [`CACHE_WAY_W-1:0]              wr_way;
    logic [`CACHE_IDX_W+`CACHE_OFS_W-1:0] wr_addr;
    logic [31:0]                          wr_data;
    logic [`CACHE_IDX_W+`CACHE_OFS_W-1:0] rd_index;
    logic [`CACHE_WAYS-1:0][31:0]         rd_words;

    tag_lookup i_tag_lookup (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .busy       (busy),
        .tag_upd_we (tag_upd_we),
        .tag_upd    (tag_upd),
        .lookup     (lookup)
    );

    data_store i_data_store (
        .clk      (clk),
        .rd_index (rd_index),
        .wr_en    (wr_en),
        .wr_way   (wr_way),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_words (rd_words)
    );

    line_transfer i_line_transfer (
        .clk        (clk),
        .rst        (rst),
        .lookup     (lookup),
        .cpu_addr   (cpu_req.addr),
        .rd_words   (rd_words),
        .xm_ready   (xm_ready),
        .xm_rdata   (xm_rdata),
        .xm_req     (xm_req),
        .busy       (busy),
        .tag_upd_we (tag_upd_we),
        .tag_upd    (tag_upd),
        .wr_en      (wr_en),
        .wr_way     (wr_way),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_index   (rd_index),
        .cpu_resp   (cpu_resp)
    );

endmodule

// File: ext_mem_model.sv
// External memory model with pattern fill, write storage and random ready delay.
`timescale 1ns/10ps
`include "cache_macros.svh"

module ext_mem_model #(
    parameter logic [31:0] seed = 32'h1
) (
    input  logic               clk,
    input  logic               rst,
    input  cache_pkg::xm_req_t xm_req,
    output logic               xm_ready,
    output logic [31:0]        xm_rdata
);

    // Only written words are stored, the rest read as the pattern.
    logic [31:0] mem [logic [`CACHE_ALEN-3:0]];
    int unsigned wait_cnt;

    function automatic logic [31:0] read_word(logic [`CACHE_ALEN-3:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return 32'(addr) ^ 32'h3c96_a5f0;
    endfunction

    initial begin
        void'($urandom(seed));
        xm_ready = 1'b0;
        xm_rdata = '0;
        wait_cnt = $urandom % 4;
        forever begin
            @(posedge clk);
            if (rst) begin
                xm_ready <= 1'b0;
            end else if (xm_ready) begin
                // Transfer taken on this edge.
                xm_ready <= 1'b0;
                wait_cnt = $urandom % 4;
            end else if (xm_req.re || xm_req.we) begin
                if (wait_cnt == 0) begin
                    xm_ready <= 1'b1;
                    if (xm_req.we) begin
                        mem[xm_req.addr.flat] = xm_req.wdata;
                    end else begin
                        xm_rdata <= read_word(xm_req.addr.flat);
                    end
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

endmodule

// File: tb_cache.sv
// Cache testbench with clock, reset, case replay, golden memory, checks and timeout.
`timescale 1ns/10ps
`include "cache_macros.svh"

module tb_cache;
    import cache_pkg::*;

    localparam int cycles_per_case = 400;

    logic        clk;
    logic        rst;
    cpu_req_t    cpu_req;
    cpu_resp_t   cpu_resp;
    xm_req_t     xm_req;
    logic        xm_ready;
    logic [31:0] xm_rdata;

    // Access kind, word address, write data, expected external reads and writes.
    logic                   case_we    [$];
    logic [`CACHE_ALEN-3:0] case_addr  [$];
    logic [31:0]            case_wdata [$];
    int                     case_nrd   [$];
    int                     case_nwr   [$];

    logic [31:0] golden [logic [`CACHE_ALEN-3:0]];
    word_addr_u  cur_addr;
    int          xm_reads;
    int          xm_writes;
    int          checks;
    int          errors;
    int          cycles;
    int          cycle_limit;
    logic        timed_out;

    cache_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .cpu_resp (cpu_resp),
        .xm_req   (xm_req),
        .xm_ready (xm_ready),
        .xm_rdata (xm_rdata)
    );

    ext_mem_model #(.seed(32'h538387dc)) i_mem (
        .clk      (clk),
        .rst      (rst),
        .xm_req   (xm_req),
        .xm_ready (xm_ready),
        .xm_rdata (xm_rdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("error: %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Pattern until the word is written.
    function automatic logic [31:0] expected_word(logic [`CACHE_ALEN-3:0] addr);
        if (golden.exists(addr)) begin
            return golden[addr];
        end
        return 32'(addr) ^ 32'h3c96_a5f0;
    endfunction

    // External transfers of the current access walk the line in order.
    always @(negedge clk) begin
        if (!rst && xm_ready && xm_req.re) begin
            compare_word("fill address", 32'(xm_req.addr.flat),
                         32'({cur_addr.f.tag, cur_addr.f.index, `CACHE_OFS_W'(xm_reads)}));
            xm_reads++;
        end
        if (!rst && xm_ready && xm_req.we) begin
            compare_word("write-back address",
                         32'({xm_req.addr.f.index, xm_req.addr.f.offset}),
                         32'({cur_addr.f.index, `CACHE_OFS_W'(xm_writes)}));
            compare_word($sformatf("write-back data at %h", xm_req.addr.flat),
                         xm_req.wdata, expected_word(xm_req.addr.flat));
            xm_writes++;
        end
    end

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        string       op;
        logic [31:0] addr;
        logic [31:0] data;
        int          nrd;
        int          nwr;
        fd = $fopen("cache_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open cache_cases.txt for reading.");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%s %h %h %d %d", op, addr, data, nrd, nwr);
                if (n == 5 && (op == "R" || op == "W")) begin
                    case_we.push_back(op == "W");
                    case_addr.push_back(addr[`CACHE_ALEN-3:0]);
                    case_wdata.push_back(data);
                    case_nrd.push_back(nrd);
                    case_nwr.push_back(nwr);
                end
            end
            $fclose(fd);
            if (case_we.size() == 0) begin
                errors++;
                $display("No cases found in cache_cases.txt.");
            end
        end
    endtask

    task automatic run_case(input int i);
        word_addr_u  addr;
        logic        done;
        logic [31:0] rdata;
        addr.flat = case_addr[i];
        done      = 1'b0;
        rdata     = '0;
        @(posedge clk);
        cur_addr  = addr;
        xm_reads  = 0;
        xm_writes = 0;
        cpu_req.re    <= !case_we[i];
        cpu_req.we    <= case_we[i];
        cpu_req.addr  <= addr;
        cpu_req.wdata <= case_wdata[i];
        // Captured on the next edge, then ready marks the end of the access.
        @(posedge clk);
        while (!done) begin
            @(negedge clk);
            if (cpu_resp.ready) begin
                done  = 1'b1;
                rdata = cpu_resp.rdata;
            end else if (cycles >= cycle_limit) begin
                done      = 1'b1;
                timed_out = 1'b1;
                errors++;
                $display("Run timed out after %0d cycles: case %0d never got ready.",
                         cycles, i);
            end
        end
        if (!timed_out) begin
            if (case_we[i]) begin
                golden[addr.flat] = case_wdata[i];
            end else begin
                compare_word($sformatf("read data at %h", addr.flat), rdata,
                             expected_word(addr.flat));
            end
            compare_word($sformatf("case %0d external reads", i), 32'(xm_reads),
                         32'(case_nrd[i]));
            compare_word($sformatf("case %0d external writes", i), 32'(xm_writes),
                         32'(case_nwr[i]));
        end
    endtask

    initial begin
        cpu_req   = '0;
        rst       = 1'b1;
        checks    = 0;
        errors    = 0;
        cycles    = 0;
        timed_out = 1'b0;
        xm_reads  = 0;
        xm_writes = 0;
        cur_addr  = '0;
        load_cases();
        cycle_limit = cycles_per_case * (case_we.size() + 1);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // Idle cache before the first request.
        compare_word("ready after reset", 32'(cpu_resp.ready), 32'd1);
        compare_word("xm re after reset", 32'(xm_req.re), 32'd0);
        compare_word("xm we after reset", 32'(xm_req.we), 32'd0);
        for (int i = 0; i < case_we.size() && !timed_out; i++) begin
            run_case(i);
        end
        $display("%0d cases, %0d checks, %0d errors", case_we.size(), checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: cache_cases.txt
# op word_addr(hex) wdata(hex) ext_reads ext_writes
# One CPU access per line; the last two columns are the expected external transfers.
R 000234 00000000 16 0
W 000234 11223344 0 0
R 000234 00000000 0 0
R 000235 00000000 0 0
R 000430 00000000 16 0
R 000630 00000000 16 16
R 000234 00000000 16 0
R 000A70 00000000 16 0
R 000C71 00000000 16 0
R 000E72 00000000 16 0
R 000C73 00000000 0 0
R 000A74 00000000 16 0
W 0010A2 DEAD0001 16 0
R 0012B5 00000000 16 0
R 0010A2 00000000 0 0
W 0014AF 0BADF00D 16 0
W 0012C7 13579BDF 16 0
R 0012A3 00000000 16 16
R 0010A2 00000000 16 16
R 0014AF 00000000 16 0
W 0010D0 2468ACE0 16 0
W 0012B5 CAFE0005 0 0
R 0014B1 00000000 16 0
R 0010B6 00000000 16 16
R 0012B5 00000000 16 0
W 0014C7 55AA55AA 16 0
R 0012C7 00000000 0 0
R 0010C7 00000000 16 16
R 0014D0 00000000 16 0
R 0010D0 00000000 0 0

// File: list.f
+incdir+.
cache_pkg.sv
tag_lookup.sv
data_store.sv
line_transfer.sv
cache_top.sv
ext_mem_model.sv
tb_cache.sv

// File: Makefile
# Verilator build and run of the cache testbench.
VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTS PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
